// File: all.f
logic/sap_pkg.sv
logic/program_counter.sv
logic/memory_unit.sv
logic/alu.sv
logic/cpu_datapath.sv
logic/control_block.sv
logic/sap_cpu_top.sv
testbench/tb_clock_gen.sv
testbench/tb_sap_cpu.sv

// File: logic/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire            clk,
    input  wire            rst_n,
    input  sap_pkg::word_t acc,
    input  sap_pkg::word_t b,
    input  wire            sub,
    input  wire            flags_load,
    output sap_pkg::word_t result,
    output logic           cf,
    output logic           zf
);
    import sap_pkg::*;

    // second operand, inverted for subtract
    word_t b_operand;

    // 9 bits so the carry out of bit 7 is kept
    logic [8:0] sum_ext;

    always_comb begin
        b_operand = sub ? ~b : b;
        // sub adds the +1 of the two's complement
        sum_ext = {1'b0, acc} + {1'b0, b_operand} + {8'd0, sub};
    end

    assign result = sum_ext[7:0];

    // flags only move at T5 of add or sub
    // top level ties load mode into rst_n here
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cf <= 1'b0;
            zf <= 1'b0;
        end else if (flags_load) begin
            // on sub a carry means no borrow
            cf <= sum_ext[8];
            zf <= (sum_ext[7:0] == '0);
        end
    end

endmodule

`default_nettype wire

// File: logic/control_block.sv
`timescale 1ns/1ps
`default_nettype none

module control_block (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               run,
    input  sap_pkg::opcode_t  opcode,
    input  wire               cf,
    input  wire               zf,
    output sap_pkg::bus_src_t bus_src,
    output logic              mar_load,
    output logic              ram_write,
    output logic              ir_load,
    output logic              acc_load,
    output logic              b_load,
    output logic              out_load,
    output logic              pc_inc,
    output logic              pc_load,
    output logic              sub,
    output logic              flags_load,
    output logic              halted
);
    import sap_pkg::*;

    tstate_t state;
    tstate_t state_next;

    // lda, add, sub and sta fetch a data byte
    logic mem_op;
    // add or sub, result back into A at T5
    logic arith_op;
    // jmp always, jc and jz on their flag
    logic jump_taken;

    assign mem_op     = (opcode == OP_LDA) || (opcode == OP_ADD) ||
                        (opcode == OP_SUB) || (opcode == OP_STA);
    assign arith_op   = (opcode == OP_ADD) || (opcode == OP_SUB);
    assign jump_taken = (opcode == OP_JMP) ||
                        ((opcode == OP_JC) && cf) ||
                        ((opcode == OP_JZ) && zf);

    // five steps on every path, taken jumps too
    always_comb begin
        state_next = state;
        if (!run) begin
            // load mode parks in T1
            state_next = T1;
        end else begin
            unique case (state)
                T1:      state_next = T2;
                T2:      state_next = T3;
                T3:      state_next = (opcode == OP_HLT) ? T_HALT : T4;
                T4:      state_next = T5;
                T5:      state_next = T1;
                default: state_next = T_HALT;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= T1;
        end else begin
            state <= state_next;
        end
    end

    assign halted = (state == T_HALT);

    // microcode, one bus grant per cycle
    always_comb begin
        bus_src    = SRC_NONE;
        mar_load   = 1'b0;
        ram_write  = 1'b0;
        ir_load    = 1'b0;
        acc_load   = 1'b0;
        b_load     = 1'b0;
        out_load   = 1'b0;
        pc_inc     = 1'b0;
        pc_load    = 1'b0;
        sub        = 1'b0;
        flags_load = 1'b0;
        // nothing moves in load mode
        if (run) begin
            unique case (state)
                T1: begin
                    // fetch address
                    bus_src  = SRC_PC;
                    mar_load = 1'b1;
                end
                T2: begin
                    bus_src = SRC_RAM;
                    ir_load = 1'b1;
                    pc_inc  = 1'b1;
                end
                T3: begin
                    if (mem_op) begin
                        bus_src  = SRC_IR_OPERAND;
                        mar_load = 1'b1;
                    end else if (opcode == OP_LDI) begin
                        bus_src  = SRC_IR_OPERAND;
                        acc_load = 1'b1;
                    end else if (jump_taken) begin
                        bus_src = SRC_IR_OPERAND;
                        pc_load = 1'b1;
                    end else if (opcode == OP_OUT) begin
                        bus_src  = SRC_ACC;
                        out_load = 1'b1;
                    end
                end
                T4: begin
                    if (opcode == OP_LDA) begin
                        bus_src  = SRC_RAM;
                        acc_load = 1'b1;
                    end else if (arith_op) begin
                        bus_src = SRC_RAM;
                        b_load  = 1'b1;
                    end else if (opcode == OP_STA) begin
                        bus_src   = SRC_ACC;
                        ram_write = 1'b1;
                    end
                end
                T5: begin
                    if (arith_op) begin
                        bus_src    = SRC_ALU;
                        acc_load   = 1'b1;
                        flags_load = 1'b1;
                        sub        = (opcode == OP_SUB);
                    end
                end
                default: begin
                    // halted, all quiet
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/cpu_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_datapath (
    input  wire               clk,
    input  wire               rst_n,
    input  sap_pkg::bus_src_t bus_src,
    input  sap_pkg::addr_t    pc,
    input  sap_pkg::word_t    ram_data,
    input  sap_pkg::word_t    alu_result,
    input  wire               ir_load,
    input  wire               acc_load,
    input  wire               b_load,
    input  wire               out_load,
    output sap_pkg::word_t    bus,
    output sap_pkg::opcode_t  opcode,
    output sap_pkg::word_t    acc,
    output sap_pkg::word_t    b,
    output sap_pkg::word_t    out_value,
    output logic              out_valid
);
    import sap_pkg::*;

    // instruction register, opcode high and operand low
    word_t ir;

    // bus mux stands in for the tri-state bus
    // only the granted source gets through
    always_comb begin
        unique case (bus_src)
            SRC_PC:         bus = {4'b0000, pc};
            SRC_RAM:        bus = ram_data;
            SRC_IR_OPERAND: bus = {4'b0000, ir[3:0]};
            SRC_ACC:        bus = acc;
            SRC_ALU:        bus = alu_result;
            default:        bus = '0;
        endcase
    end

    assign opcode = ir[7:4];

    // every register with its load high takes the bus
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ir        <= '0;
            acc       <= '0;
            b         <= '0;
            out_value <= '0;
            out_valid <= 1'b0;
        end else begin
            if (ir_load) begin
                ir <= bus;
            end
            if (acc_load) begin
                acc <= bus;
            end
            if (b_load) begin
                b <= bus;
            end
            if (out_load) begin
                out_value <= bus;
            end
            // valid lines up with the new out_value
            out_valid <= out_load;
        end
    end

endmodule

`default_nettype wire

// File: logic/memory_unit.sv
`timescale 1ns/1ps
`default_nettype none

module memory_unit (
    input  wire            clk,
    input  wire            rst_n,
    input  wire            prog_mode,
    input  wire            prog_we,
    input  sap_pkg::addr_t prog_addr,
    input  sap_pkg::word_t prog_data,
    input  sap_pkg::word_t bus_in,
    input  wire            mar_load,
    input  wire            ram_write,
    output sap_pkg::word_t ram_data
);
    import sap_pkg::*;

    // memory address register
    addr_t mar;

    // program and data share one array
    word_t mem [RAM_DEPTH];

    // mar takes the low nibble of the bus
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mar <= '0;
        end else if (mar_load) begin
            mar <= bus_in[3:0];
        end
    end

    // single write port
    always_ff @(posedge clk) begin
        if (prog_mode) begin
            // loader owns the port in load mode
            if (prog_we) begin
                mem[prog_addr] <= prog_data;
            end
        end else if (ram_write) begin
            // sta stores the bus at the mar address
            mem[mar] <= bus_in;
        end
    end

    // read straight from the mar
    // data is ready within the same T-state
    assign ram_data = mem[mar];

endmodule

`default_nettype wire

// File: logic/program_counter.sv
`timescale 1ns/1ps
`default_nettype none

module program_counter (
    input  wire            clk,
    input  wire            rst_n,
    input  wire            run,
    input  wire            inc,
    input  wire            load,
    input  sap_pkg::addr_t load_addr,
    output sap_pkg::addr_t pc
);
    import sap_pkg::*;

    always_ff @(posedge clk) begin
        // load mode holds the pc at 0 so the run starts there
        if (!rst_n || !run) begin
            pc <= '0;
        end else if (load) begin
            // jump target taken from the bus
            pc <= load_addr;
        end else if (inc) begin
            // 4-bit add wraps 15 to 0 by itself
            pc <= pc + addr_t'(1);
        end
    end

endmodule

`default_nettype wire

// File: logic/sap_cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module sap_cpu_top (
    input  wire            clk,
    input  wire            rst_n,
    input  wire            prog_mode,
    input  wire            prog_we,
    input  sap_pkg::addr_t prog_addr,
    input  sap_pkg::word_t prog_data,
    output sap_pkg::word_t out_value,
    output wire            out_valid,
    output wire            halted
);
    import sap_pkg::*;

    // shared bus and block to block values
    word_t    bus;
    word_t    ram_data;
    word_t    alu_result;
    word_t    acc;
    word_t    b;
    addr_t    pc;
    opcode_t  opcode;
    bus_src_t bus_src;

    // flags from the alu
    wire cf;
    wire zf;

    // control lines, all active high
    wire mar_load;
    wire ram_write;
    wire ir_load;
    wire acc_load;
    wire b_load;
    wire out_load;
    wire pc_inc;
    wire pc_load;
    wire sub;
    wire flags_load;

    // cpu runs whenever the loader is idle
    wire run;
    // flags also clear in load mode
    wire alu_rst_n;

    assign run       = ~prog_mode;
    assign alu_rst_n = rst_n & run;

    program_counter u_program_counter (
        .clk       (clk),
        .rst_n     (rst_n),
        .run       (run),
        .inc       (pc_inc),
        .load      (pc_load),
        .load_addr (bus[3:0]),
        .pc        (pc)
    );

    memory_unit u_memory_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .prog_mode (prog_mode),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .bus_in    (bus),
        .mar_load  (mar_load),
        .ram_write (ram_write),
        .ram_data  (ram_data)
    );

    alu u_alu (
        .clk        (clk),
        .rst_n      (alu_rst_n),
        .acc        (acc),
        .b          (b),
        .sub        (sub),
        .flags_load (flags_load),
        .result     (alu_result),
        .cf         (cf),
        .zf         (zf)
    );

    cpu_datapath u_cpu_datapath (
        .clk        (clk),
        .rst_n      (rst_n),
        .bus_src    (bus_src),
        .pc         (pc),
        .ram_data   (ram_data),
        .alu_result (alu_result),
        .ir_load    (ir_load),
        .acc_load   (acc_load),
        .b_load     (b_load),
        .out_load   (out_load),
        .bus        (bus),
        .opcode     (opcode),
        .acc        (acc),
        .b          (b),
        .out_value  (out_value),
        .out_valid  (out_valid)
    );

    control_block u_control_block (
        .clk        (clk),
        .rst_n      (rst_n),
        .run        (run),
        .opcode     (opcode),
        .cf         (cf),
        .zf         (zf),
        .bus_src    (bus_src),
        .mar_load   (mar_load),
        .ram_write  (ram_write),
        .ir_load    (ir_load),
        .acc_load   (acc_load),
        .b_load     (b_load),
        .out_load   (out_load),
        .pc_inc     (pc_inc),
        .pc_load    (pc_load),
        .sub        (sub),
        .flags_load (flags_load),
        .halted     (halted)
    );

endmodule

`default_nettype wire

// File: logic/sap_pkg.sv
`default_nettype none

package sap_pkg;

    // data path word, also one memory byte
    typedef logic [7:0] word_t;

    // memory address and program counter value
    typedef logic [3:0] addr_t;

    // upper nibble of an instruction
    typedef logic [3:0] opcode_t;

    // 16 bytes, set by the 4-bit operand
    localparam int RAM_DEPTH = 16;

    // opcodes, anything not listed runs as a nop
    localparam opcode_t OP_LDA = 4'd0;
    localparam opcode_t OP_ADD = 4'd1;
    localparam opcode_t OP_SUB = 4'd2;
    localparam opcode_t OP_STA = 4'd3;
    localparam opcode_t OP_LDI = 4'd4;
    localparam opcode_t OP_JMP = 4'd5;
    localparam opcode_t OP_JC  = 4'd6;
    localparam opcode_t OP_JZ  = 4'd7;
    localparam opcode_t OP_OUT = 4'd14;
    localparam opcode_t OP_HLT = 4'd15;

    // which source owns the bus this cycle
    typedef enum logic [2:0] {
        SRC_NONE       = 3'd0,
        SRC_PC         = 3'd1,
        SRC_RAM        = 3'd2,
        SRC_IR_OPERAND = 3'd3,
        SRC_ACC        = 3'd4,
        SRC_ALU        = 3'd5
    } bus_src_t;

    // microcode step, T_HALT parks the sequencer
    typedef enum logic [2:0] {T1, T2, T3, T4, T5, T_HALT} tstate_t;

endpackage

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reset held for 8 rising edges, released just after an edge
    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: testbench/tb_sap_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sap_cpu;
    import sap_pkg::*;

    // 16 loader writes plus entry and exit
    localparam int LOAD_CYCLES = RAM_DEPTH + 4;

    logic  clk;
    logic  por_rst_n;
    logic  test_rst_n;
    logic  dut_rst_n;
    logic  prog_mode;
    logic  prog_we;
    addr_t prog_addr;
    word_t prog_data;
    word_t out_value;
    logic  out_valid;
    logic  halted;

    // program image shared by the loader and the model
    word_t image [RAM_DEPTH];
    word_t exp_q [$];
    word_t expected_value;
    int    model_steps;
    bit    halt_expected;
    bit    halt_seen;
    int    error_count;
    int    pass_tests;
    int    fail_tests;
    int    cycles_used;
    int    cycle_budget = 24;
    integer seed;

    tb_clock_gen u_tb_clock_gen (
        .clk   (clk),
        .rst_n (por_rst_n)
    );

    // power-on reset or a reset forced mid-run
    assign dut_rst_n = por_rst_n & test_rst_n;

    sap_cpu_top u_sap_cpu_top (
        .clk       (clk),
        .rst_n     (dut_rst_n),
        .prog_mode (prog_mode),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .out_value (out_value),
        .out_valid (out_valid),
        .halted    (halted)
    );

    function automatic word_t encode(input opcode_t op, input addr_t operand);
        return {op, operand};
    endfunction

    task automatic next_random(output word_t v);
        logic [31:0] r;
        r = $random(seed);
        v = r[7:0];
    endtask

    // unused bytes hold a nop tagged with their address
    task automatic fill_image();
        int i;
        for (i = 0; i < RAM_DEPTH; i++) begin
            image[i] = {4'h8, 4'(i)};
        end
    endtask

    // instruction-level model that fills exp_q with the outputs in order
    task automatic predict(input int max_outs);
        word_t      mem [RAM_DEPTH];
        addr_t      pc;
        word_t      a;
        word_t      ins;
        logic [8:0] wide;
        bit         cf;
        bit         zf;
        int         i;
        for (i = 0; i < RAM_DEPTH; i++) begin
            mem[i] = image[i];
        end
        pc = '0;
        a = '0;
        cf = 1'b0;
        zf = 1'b0;
        model_steps = 0;
        halt_expected = 1'b0;
        exp_q.delete();
        while (!halt_expected && model_steps < 64 && exp_q.size() < max_outs) begin
            ins = mem[pc];
            pc = pc + 4'd1;
            model_steps++;
            case (ins[7:4])
                OP_LDA: a = mem[ins[3:0]];
                OP_ADD: begin
                    wide = {1'b0, a} + {1'b0, mem[ins[3:0]]};
                    cf = wide[8];
                    a = wide[7:0];
                    zf = (a == 8'h00);
                end
                OP_SUB: begin
                    // carry set means no borrow
                    cf = (a >= mem[ins[3:0]]);
                    a = a - mem[ins[3:0]];
                    zf = (a == 8'h00);
                end
                OP_STA: mem[ins[3:0]] = a;
                OP_LDI: a = {4'h0, ins[3:0]};
                OP_JMP: pc = ins[3:0];
                OP_JC:  if (cf) pc = ins[3:0];
                OP_JZ:  if (zf) pc = ins[3:0];
                OP_OUT: exp_q.push_back(a);
                OP_HLT: halt_expected = 1'b1;
                default: ;
            endcase
        end
    endtask

    task automatic load_image();
        int i;
        @(posedge clk);
        #1;
        prog_mode = 1'b1;
        for (i = 0; i < RAM_DEPTH; i++) begin
            prog_we = 1'b1;
            prog_addr = 4'(i);
            prog_data = image[i];
            @(posedge clk);
            #1;
        end
        prog_we = 1'b0;
        // halted is low by now so the halt check can be rearmed
        halt_seen = 1'b0;
        prog_mode = 1'b0;
    endtask

    // done on halt for halting programs or else once every expected value is seen
    task automatic wait_for_done(input int limit, output bit done);
        int n;
        n = 0;
        done = 1'b0;
        while (!done && n < limit) begin
            @(posedge clk);
            n++;
            done = halt_expected ? halt_seen : (exp_q.size() == 0);
        end
    endtask

    task automatic run_program(input int max_outs);
        bit done;
        predict(max_outs);
        cycle_budget += 2 * (5 * model_steps + LOAD_CYCLES);
        load_image();
        wait_for_done(5 * model_steps + 10, done);
        assert (done) else begin
            $display("program did not finish within %0d cycles", 5 * model_steps + 10);
            error_count++;
        end
        // idle a while so a stray out_valid after halt shows up
        if (halt_expected) begin
            repeat (8) @(posedge clk);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        assert (exp_q.size() == 0) else begin
            $display("%0d expected output values never appeared", exp_q.size());
            error_count++;
        end
        exp_q.delete();
        if (error_count == errs_before) begin
            pass_tests++;
            $display("PASS   %s", name);
        end else begin
            fail_tests++;
            $display("FAILED %s", name);
        end
    endtask

    // output monitor sampled mid-cycle
    always @(negedge clk) begin
        if (dut_rst_n === 1'b1) begin
            assert (!(out_valid === 1'b1 && halted === 1'b1)) else begin
                $display("out_valid pulsed while the cpu was halted");
                error_count++;
            end
            if (out_valid === 1'b1) begin
                assert (exp_q.size() != 0) else begin
                    $display("out_valid pulsed with no value left to expect");
                    error_count++;
                end
                if (exp_q.size() != 0) begin
                    expected_value = exp_q.pop_front();
                    assert (out_value === expected_value) else begin
                        $display("FAILED out_value: expected %h, got %h",
                                 expected_value, out_value);
                        error_count++;
                    end
                end
            end
            if (halted === 1'b1 && !halt_seen) begin
                halt_seen = 1'b1;
                assert (halt_expected && exp_q.size() == 0) else begin
                    $display("halted rose before the program reached its HLT");
                    error_count++;
                end
            end
        end
    end

    // budget grows as each test is predicted
    initial begin : watchdog
        cycles_used = 0;
        while (cycles_used <= cycle_budget) begin
            @(posedge clk);
            cycles_used++;
        end
        $display("watchdog expired after %0d cycles", cycles_used);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin : main
        int    errs_before;
        word_t d;
        word_t e;
        seed = 32'h0edec46c;
        test_rst_n = 1'b1;
        // load mode until the first image is in
        prog_mode = 1'b1;
        prog_we = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        error_count = 0;
        pass_tests = 0;
        fail_tests = 0;
        halt_seen = 1'b0;
        halt_expected = 1'b0;
        wait (por_rst_n === 1'b1);

        // lda, out, hlt
        fill_image();
        image[0] = encode(OP_LDA, 4'd14);
        image[1] = encode(OP_OUT, 4'd0);
        image[2] = encode(OP_HLT, 4'd0);
        next_random(image[14]);
        errs_before = error_count;
        run_program(16);
        report_test("load_and_output", errs_before);

        // wrapped sum then difference
        fill_image();
        image[0] = encode(OP_LDA, 4'd13);
        image[1] = encode(OP_ADD, 4'd14);
        image[2] = encode(OP_OUT, 4'd0);
        image[3] = encode(OP_SUB, 4'd15);
        image[4] = encode(OP_OUT, 4'd0);
        image[5] = encode(OP_HLT, 4'd0);
        next_random(image[13]);
        next_random(image[14]);
        next_random(image[15]);
        errs_before = error_count;
        run_program(16);
        report_test("add_and_sub", errs_before);

        // sta into address 12 then read back
        fill_image();
        next_random(d);
        image[0] = encode(OP_LDI, d[3:0]);
        image[1] = encode(OP_STA, 4'd12);
        image[2] = encode(OP_LDI, 4'd0);
        image[3] = encode(OP_LDA, 4'd12);
        image[4] = encode(OP_OUT, 4'd0);
        image[5] = encode(OP_HLT, 4'd0);
        errs_before = error_count;
        run_program(16);
        report_test("store_and_reload", errs_before);

        // A-A sets carry and zero so both jumps are taken
        // small add leaves both clear so neither jump is taken
        fill_image();
        next_random(d);
        next_random(e);
        e = (e & 8'h3f) + 8'd1;
        image[0]  = encode(OP_LDA, 4'd15);
        image[1]  = encode(OP_SUB, 4'd15);
        image[2]  = encode(OP_JC, 4'd4);
        image[3]  = encode(OP_HLT, 4'd0);
        image[4]  = encode(OP_JZ, 4'd6);
        image[5]  = encode(OP_HLT, 4'd0);
        image[6]  = encode(OP_OUT, 4'd0);
        image[7]  = encode(OP_LDI, 4'd1);
        image[8]  = encode(OP_ADD, 4'd14);
        image[9]  = encode(OP_JC, 4'd12);
        image[10] = encode(OP_JZ, 4'd12);
        image[11] = encode(OP_OUT, 4'd0);
        image[12] = encode(OP_HLT, 4'd0);
        image[14] = e;
        image[15] = d;
        errs_before = error_count;
        run_program(16);
        report_test("conditional_jumps", errs_before);

        // counter loop then reset mid-run and the same count again
        fill_image();
        next_random(d);
        image[0]  = encode(OP_LDI, d[3:0]);
        image[1]  = encode(OP_ADD, 4'd15);
        image[2]  = encode(OP_OUT, 4'd0);
        image[3]  = encode(OP_JMP, 4'd1);
        image[15] = 8'h01;
        errs_before = error_count;
        run_program(6);
        // reset while the loop still runs and for longer than one output period
        @(posedge clk);
        #1;
        test_rst_n = 1'b0;
        cycle_budget += 40;
        @(posedge clk);
        repeat (16) begin
            @(negedge clk);
            assert (out_valid === 1'b0) else begin
                $display("FAILED out_valid during reset: expected 0, got %h", out_valid);
                error_count++;
            end
            assert (halted === 1'b0) else begin
                $display("FAILED halted during reset: expected 0, got %h", halted);
                error_count++;
            end
        end
        // load mode before reset ends so the cpu waits for the new image
        @(posedge clk);
        #1;
        prog_mode = 1'b1;
        @(posedge clk);
        #1;
        test_rst_n = 1'b1;
        run_program(6);
        report_test("jmp_loop_with_reset", errs_before);

        $display("tests passed %0d, tests failed %0d, failed checks %0d",
                 pass_tests, fail_tests, error_count);
        if (fail_tests == 0 && error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
